// File: logic/dMemSs_settings.svh
`ifndef DMEMSS_SETTINGS_SVH
`define DMEMSS_SETTINGS_SVH

// ==========================================================================
// Memory map
// ==========================================================================
`define CR_MEM_BASE        32'h0002_0000   // Control registers
`define CR_MEM_SIZE        32'd4096        // 4 KB window
`define CR_OFFSET_BITS     12              // Byte offset inside the CR window
`define VGA_MEM_BASE       32'h0003_0000   // Frame buffer
`define VGA_MEM_WORDS      32'd9600        // 640x480 bits, 32 pixels per word
`define VGA_ADDR_BITS      14              // Word index width of the frame buffer

// ==========================================================================
// Video timing, 640x480 at one pixel per clock
// ==========================================================================
`define H_VISIBLE          640
`define H_FRONT            16
`define H_SYNC             96
`define H_TOTAL            800
`define V_VISIBLE          480
`define V_FRONT            10
`define V_SYNC             2
`define V_TOTAL            525
`define VGA_WORDS_PER_LINE (`H_VISIBLE / 32)   // 20 words per scan line

`endif

// File: logic/dMemSsPkg.sv
`default_nettype none

`include "dMemSs_settings.svh"

package dMemSsPkg;

   // Core request in Q103H
   typedef struct packed {
      logic [31:0] address;
      logic [31:0] data;
      logic [3:0]  byteEn;
      logic        wrEn;
      logic        rdEn;
   } tCore2MemReq;

   // Result of the address decode
   typedef enum logic [1:0] {
      REGION_NONE = 2'd0,
      REGION_CR   = 2'd1,
      REGION_VGA  = 2'd2
   } tMemRegion;

   // Control register byte offsets, word aligned
   typedef enum logic [`CR_OFFSET_BITS-1:0] {
      CR_KBD_SCANCODE = 'h00,   // Read pops the keyboard
      CR_KBD_READY    = 'h04,
      CR_SWITCH       = 'h08,
      CR_KEY          = 'h0C,
      CR_LED          = 'h10,
      CR_SEG7_0       = 'h14,   // Digits 0..3
      CR_SEG7_1       = 'h18,   // Digits 4..5
      CR_VGA_X        = 'h1C,
      CR_VGA_Y        = 'h20
   } tCrReg;

   typedef struct packed {
      logic [3:0] red;
      logic [3:0] green;
      logic [3:0] blue;
      logic       hSync;    // Active low
      logic       vSync;    // Active low
   } tVgaOut;

   typedef struct packed {
      logic [7:0] scanCode;
      logic       valid;
   } tKbdDataRd;

   typedef struct packed {
      logic pop;
   } tKbdCtrl;

   typedef struct packed {
      logic [9:0] switches;
      logic [3:0] keys;
   } tFpgaIn;

   typedef struct packed {
      logic [9:0]      led;
      logic [5:0][7:0] seg7;   // One byte per digit
   } tFpgaOut;

endpackage

`default_nettype wire

// File: logic/dMemReqIf.sv
`timescale 1ns/100ps
`default_nettype none

// Request path from the router to one memory region
interface dMemReqIf;

   logic [31:0] address;   // Full core address, not rebased
   logic [31:0] wrData;
   logic [3:0]  byteEn;
   logic        wrEn;      // Only high when the address hits this region
   logic        rdEn;
   logic [31:0] rdData;    // Valid the cycle after rdEn, held until the next read

   modport router (
      output address,
      output wrData,
      output byteEn,
      output wrEn,
      output rdEn,
      input  rdData
   );

   modport target (
      input  address,
      input  wrData,
      input  byteEn,
      input  wrEn,
      input  rdEn,
      output rdData
   );

endinterface

`default_nettype wire

// File: logic/dMemRouter.sv
`timescale 1ns/100ps
`default_nettype none

`include "dMemSs_settings.svh"

module dMemRouter
   import dMemSsPkg::*;
(
   input  logic            Clock,
   input  logic            rstN,
   input  var tCore2MemReq coreReq,    // Q103H
   output logic [31:0]     rdRsp,      // Q104H
   dMemReqIf.router        crReqIf,
   dMemReqIf.router        vgaReqIf
);

   tMemRegion regionQ103H;
   tMemRegion rdRegionQ104H;

   // ==========================================================================
   // Region decode, Q103H
   // ==========================================================================
   always_comb begin
      regionQ103H = REGION_NONE;    // Unmapped by default
      if ((coreReq.address >= `CR_MEM_BASE) &&
          (coreReq.address <  `CR_MEM_BASE + `CR_MEM_SIZE)) begin
         regionQ103H = REGION_CR;
      end else if ((coreReq.address >= `VGA_MEM_BASE) &&
                   (coreReq.address <  `VGA_MEM_BASE + (`VGA_MEM_WORDS * 32'd4))) begin
         regionQ103H = REGION_VGA;
      end
   end

   // ==========================================================================
   // Request fan-out
   // ==========================================================================
   // Payload goes to both regions as is
   assign crReqIf.address  = coreReq.address;
   assign crReqIf.wrData   = coreReq.data;
   assign crReqIf.byteEn   = coreReq.byteEn;
   assign vgaReqIf.address = coreReq.address;
   assign vgaReqIf.wrData  = coreReq.data;
   assign vgaReqIf.byteEn  = coreReq.byteEn;

   // Strobes only reach the region that was hit
   assign crReqIf.wrEn  = coreReq.wrEn && (regionQ103H == REGION_CR);
   assign crReqIf.rdEn  = coreReq.rdEn && (regionQ103H == REGION_CR);
   assign vgaReqIf.wrEn = coreReq.wrEn && (regionQ103H == REGION_VGA);
   assign vgaReqIf.rdEn = coreReq.rdEn && (regionQ103H == REGION_VGA);
   // Unmapped writes fall through here and are lost

   // ==========================================================================
   // Read response, Q104H
   // ==========================================================================
   // Remember where the last read went, targets hold their data the same way
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         rdRegionQ104H <= REGION_NONE;
      end else if (coreReq.rdEn) begin
         rdRegionQ104H <= regionQ103H;
      end
   end

   always_comb begin
      unique case (rdRegionQ104H)
         REGION_CR:  rdRsp = crReqIf.rdData;
         REGION_VGA: rdRsp = vgaReqIf.rdData;
         default:    rdRsp = '0;              // Unmapped read returns zero
      endcase
   end

   // Core never issues a load and a store together
   assert property (@(posedge Clock) disable iff (!rstN)
      !(coreReq.wrEn && coreReq.rdEn))
      else $error("dMemRouter: wrEn and rdEn high together");

endmodule

`default_nettype wire

// File: logic/crMem.sv
`timescale 1ns/100ps
`default_nettype none

`include "dMemSs_settings.svh"

module crMem
   import dMemSsPkg::*;
(
   input  logic        Clock,
   input  logic        rstN,
   dMemReqIf.target    reqIf,
   input  logic [9:0]  vgaCounterX,
   input  logic [9:0]  vgaCounterY,
   input  logic [7:0]  kbdScanCode,
   input  logic        kbdValid,
   output logic        kbdPop,
   input  logic [9:0]  fpgaSwitch,
   input  logic [3:0]  fpgaKey,
   output logic [9:0]  fpgaLed,
   output logic [47:0] fpgaSeg7
);

   tCrReg       crOffset;
   tKbdDataRd   kbdIn;
   tKbdCtrl     kbdCtrl;
   tFpgaIn      fpgaIn;
   tFpgaOut     fpgaOutQ;      // LED and 7-segment registers
   logic [31:0] rdDataNext;

   // Word offset inside the 4 KB window with byte lanes dropped
   assign crOffset = tCrReg'({reqIf.address[`CR_OFFSET_BITS-1:2], 2'b00});

   assign kbdIn.scanCode  = kbdScanCode;
   assign kbdIn.valid     = kbdValid;
   assign fpgaIn.switches = fpgaSwitch;
   assign fpgaIn.keys     = fpgaKey;

   // ==========================================================================
   // Writable registers
   // ==========================================================================
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         fpgaOutQ <= '0;   // LEDs and digits dark
      end else if (reqIf.wrEn) begin
         case (crOffset)
            CR_LED: begin
               if (reqIf.byteEn[0]) fpgaOutQ.led[7:0] <= reqIf.wrData[7:0];
               if (reqIf.byteEn[1]) fpgaOutQ.led[9:8] <= reqIf.wrData[9:8];
            end
            CR_SEG7_0: begin
               for (int i = 0; i < 4; i++) begin
                  if (reqIf.byteEn[i]) fpgaOutQ.seg7[i] <= reqIf.wrData[8*i +: 8];
               end
            end
            CR_SEG7_1: begin
               for (int i = 0; i < 2; i++) begin   // Upper two lanes ignored
                  if (reqIf.byteEn[i]) fpgaOutQ.seg7[4+i] <= reqIf.wrData[8*i +: 8];
               end
            end
            default: ;   // Read-only or unknown offset
         endcase
      end
   end

   assign fpgaLed  = fpgaOutQ.led;
   assign fpgaSeg7 = fpgaOutQ.seg7;

   // ==========================================================================
   // Read path
   // ==========================================================================
   always_comb begin
      case (crOffset)
         CR_KBD_SCANCODE: rdDataNext = {24'b0, kbdIn.scanCode};
         CR_KBD_READY:    rdDataNext = {31'b0, kbdIn.valid};
         CR_SWITCH:       rdDataNext = {22'b0, fpgaIn.switches};
         CR_KEY:          rdDataNext = {28'b0, fpgaIn.keys};
         CR_LED:          rdDataNext = {22'b0, fpgaOutQ.led};
         CR_SEG7_0:       rdDataNext = {fpgaOutQ.seg7[3], fpgaOutQ.seg7[2],
                                        fpgaOutQ.seg7[1], fpgaOutQ.seg7[0]};
         CR_SEG7_1:       rdDataNext = {16'b0, fpgaOutQ.seg7[5], fpgaOutQ.seg7[4]};
         CR_VGA_X:        rdDataNext = {22'b0, vgaCounterX};   // Sampled at the strobe
         CR_VGA_Y:        rdDataNext = {22'b0, vgaCounterY};
         default:         rdDataNext = '0;
      endcase
   end

   // Registered read data held between reads
   always_ff @(posedge Clock) begin
      if (reqIf.rdEn) begin
         reqIf.rdData <= rdDataNext;
      end
   end

   // ==========================================================================
   // Keyboard pop
   // ==========================================================================
   // Pulse in the strobe cycle only while the keyboard holds a code
   assign kbdCtrl.pop = reqIf.rdEn && (crOffset == CR_KBD_SCANCODE) && kbdIn.valid;
   assign kbdPop      = kbdCtrl.pop;

   // The popped code is the one returned next cycle
   assert property (@(posedge Clock) disable iff (!rstN)
      kbdPop |=> (reqIf.rdData == {24'b0, $past(kbdScanCode)}))
      else $error("crMem: popped scan code not returned");

endmodule

`default_nettype wire

// File: logic/vgaCtrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "dMemSs_settings.svh"

module vgaCtrl
   import dMemSsPkg::*;
(
   input  logic       Clock,
   input  logic       rstN,
   dMemReqIf.target   reqIf,
   output logic [9:0] vgaCounterX,
   output logic [9:0] vgaCounterY,
   output logic       inDisplayArea,
   output tVgaOut     vgaOut
);

   // Frame buffer, one bit per pixel, bit 0 is the leftmost of 32
   logic [3:0][7:0]           frameBuf [0:`VGA_MEM_WORDS-1];

   logic [`VGA_ADDR_BITS-1:0] coreIdx;
   logic [`VGA_ADDR_BITS-1:0] scanIdx;
   logic                      inDispQ0;
   logic [31:0]               pixWordQ1;   // Fetched scan word
   logic [4:0]                bitSelQ1;    // x mod 32
   logic                      inDispQ1;
   logic                      hSyncQ1;
   logic                      vSyncQ1;

   // ==========================================================================
   // Core port
   // ==========================================================================
   // Region base has zero low bits, so the word index is taken straight
   assign coreIdx = reqIf.address[`VGA_ADDR_BITS+1:2];

   always_ff @(posedge Clock) begin
      if (reqIf.wrEn) begin
         for (int i = 0; i < 4; i++) begin
            if (reqIf.byteEn[i]) frameBuf[coreIdx][i] <= reqIf.wrData[8*i +: 8];
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (reqIf.rdEn) begin
         reqIf.rdData <= frameBuf[coreIdx];   // Held until the next read
      end
   end

   // ==========================================================================
   // Scan counters
   // ==========================================================================
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         vgaCounterX <= '0;
         vgaCounterY <= '0;
      end else if (vgaCounterX == 10'(`H_TOTAL - 1)) begin
         vgaCounterX <= '0;   // End of line
         if (vgaCounterY == 10'(`V_TOTAL - 1)) vgaCounterY <= '0;
         else                                  vgaCounterY <= vgaCounterY + 10'd1;
      end else begin
         vgaCounterX <= vgaCounterX + 10'd1;
      end
   end

   // ==========================================================================
   // Stage 1, word fetch and sync decode
   // ==========================================================================
   assign inDispQ0 = (vgaCounterX < 10'(`H_VISIBLE)) && (vgaCounterY < 10'(`V_VISIBLE));

   // Park the fetch on word 0 during blanking
   assign scanIdx = inDispQ0 ?
      `VGA_ADDR_BITS'(vgaCounterY * `VGA_WORDS_PER_LINE + vgaCounterX[9:5]) : '0;

   always_ff @(posedge Clock) begin
      pixWordQ1 <= frameBuf[scanIdx];   // Second read port
      bitSelQ1  <= vgaCounterX[4:0];
   end

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         inDispQ1 <= 1'b0;
         hSyncQ1  <= 1'b1;   // Syncs idle high
         vSyncQ1  <= 1'b1;
      end else begin
         inDispQ1 <= inDispQ0;
         hSyncQ1  <= !((vgaCounterX >= 10'(`H_VISIBLE + `H_FRONT)) &&
                       (vgaCounterX <  10'(`H_VISIBLE + `H_FRONT + `H_SYNC)));
         vSyncQ1  <= !((vgaCounterY >= 10'(`V_VISIBLE + `V_FRONT)) &&
                       (vgaCounterY <  10'(`V_VISIBLE + `V_FRONT + `V_SYNC)));
      end
   end

   // ==========================================================================
   // Stage 2, bit select and outputs
   // ==========================================================================
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         inDisplayArea <= 1'b0;
         vgaOut.red    <= '0;
         vgaOut.green  <= '0;
         vgaOut.blue   <= '0;
         vgaOut.hSync  <= 1'b1;
         vgaOut.vSync  <= 1'b1;
      end else begin
         inDisplayArea <= inDispQ1;
         // Monochrome, white when the bit is set
         vgaOut.red    <= (inDispQ1 && pixWordQ1[bitSelQ1]) ? 4'hF : 4'h0;
         vgaOut.green  <= (inDispQ1 && pixWordQ1[bitSelQ1]) ? 4'hF : 4'h0;
         vgaOut.blue   <= (inDispQ1 && pixWordQ1[bitSelQ1]) ? 4'hF : 4'h0;
         vgaOut.hSync  <= hSyncQ1;
         vgaOut.vSync  <= vSyncQ1;
      end
   end

   assert property (@(posedge Clock) disable iff (!rstN)
      (vgaCounterX < 10'(`H_TOTAL)) && (vgaCounterY < 10'(`V_TOTAL)))
      else $error("vgaCtrl: scan counter out of range");

endmodule

`default_nettype wire

// File: logic/dMemSs.sv
`timescale 1ns/100ps
`default_nettype none

module dMemSs
   import dMemSsPkg::*;
(
   input  logic            Clock,
   input  logic            rstN,
   // ==========================================================================
   // Core memory stage
   // ==========================================================================
   input  var tCore2MemReq core2DmemReq,   // Q103H
   output logic [31:0]     dMemRdRsp,      // Q104H
   // ==========================================================================
   // Display
   // ==========================================================================
   output logic            inDisplayArea,
   output tVgaOut          vgaOut,
   // ==========================================================================
   // Keyboard and board
   // ==========================================================================
   input  logic [7:0]      kbdScanCode,
   input  logic            kbdValid,
   output logic            kbdPop,
   input  logic [9:0]      fpgaSwitch,
   input  logic [3:0]      fpgaKey,
   output logic [9:0]      fpgaLed,
   output logic [47:0]     fpgaSeg7
);

   logic [9:0] vgaCounterX;   // Scan position into the CR space
   logic [9:0] vgaCounterY;

   dMemReqIf crReqIf ();
   dMemReqIf vgaReqIf ();

   dMemRouter dMemRouter (
      .Clock    (Clock),
      .rstN     (rstN),
      .coreReq  (core2DmemReq),
      .rdRsp    (dMemRdRsp),
      .crReqIf  (crReqIf.router),
      .vgaReqIf (vgaReqIf.router)
   );

   crMem crMem (
      .Clock       (Clock),
      .rstN        (rstN),
      .reqIf       (crReqIf.target),
      .vgaCounterX (vgaCounterX),
      .vgaCounterY (vgaCounterY),
      .kbdScanCode (kbdScanCode),
      .kbdValid    (kbdValid),
      .kbdPop      (kbdPop),
      .fpgaSwitch  (fpgaSwitch),
      .fpgaKey     (fpgaKey),
      .fpgaLed     (fpgaLed),
      .fpgaSeg7    (fpgaSeg7)
   );

   vgaCtrl vgaCtrl (
      .Clock         (Clock),
      .rstN          (rstN),
      .reqIf         (vgaReqIf.target),
      .vgaCounterX   (vgaCounterX),
      .vgaCounterY   (vgaCounterY),
      .inDisplayArea (inDisplayArea),
      .vgaOut        (vgaOut)
   );

endmodule

`default_nettype wire

// File: tests/dMemSsTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "dMemSs_settings.svh"

module dMemSsTb
   import dMemSsPkg::*;
;

   localparam int     CLK_PERIOD   = 8;
   localparam longint FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
   localparam longint BUS_CYCLES   = 2 * `VGA_MEM_WORDS;            // Fill plus the short phases
   localparam longint SCAN_CYCLES  = 3 * FRAME_CYCLES;              // Random phase and two frames
   localparam longint WATCHDOG_NS  = 2 * (BUS_CYCLES + SCAN_CYCLES) * CLK_PERIOD;

   logic        Clock;
   logic        rstN;
   tCore2MemReq coreReq;
   logic [31:0] dMemRdRsp;
   logic        inDisplayArea;
   tVgaOut      vgaOut;
   logic [7:0]  kbdScanCode;
   logic        kbdValid;
   logic        kbdPop;
   logic [9:0]  fpgaSwitch;
   logic [3:0]  fpgaKey;
   logic [9:0]  fpgaLed;
   logic [47:0] fpgaSeg7;
   tFpgaOut     fpgaOutDut;

   // Reference model state
   logic [31:0] fbModel [0:`VGA_MEM_WORDS-1];
   logic [9:0]  ledModel;
   logic [7:0]  segModel [6];
   logic [7:0]  kbdQueue [$];
   int          histX [3];     // Scan position history with [0] now and [2] two clocks back
   int          histY [3];
   bit          scanCheckOn;

   assign fpgaOutDut.led  = fpgaLed;
   assign fpgaOutDut.seg7 = fpgaSeg7;

   dMemSs u_dMemSs (
      .Clock         (Clock),
      .rstN          (rstN),
      .core2DmemReq  (coreReq),
      .dMemRdRsp     (dMemRdRsp),
      .inDisplayArea (inDisplayArea),
      .vgaOut        (vgaOut),
      .kbdScanCode   (kbdScanCode),
      .kbdValid      (kbdValid),
      .kbdPop        (kbdPop),
      .fpgaSwitch    (fpgaSwitch),
      .fpgaKey       (fpgaKey),
      .fpgaLed       (fpgaLed),
      .fpgaSeg7      (fpgaSeg7)
   );

   initial begin
      Clock = 1'b0;
      forever #(CLK_PERIOD / 2) Clock = ~Clock;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before all tests finished");
      $display("Test FAILED");
      $fatal(1, "Run stopped by the watchdog");
   end

   // ==========================================================================
   // Compare tasks
   // ==========================================================================
   task automatic stopOnError(string line);
      $display("%s", line);
      $display("Test FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic checkRdRsp(logic [31:0] got, logic [31:0] exp);
      if (got !== exp)
         stopOnError($sformatf("** Error: dMemRdRsp got 0x%08h expected 0x%08h", got, exp));
   endtask

   task automatic checkVgaOut(tVgaOut got, logic gotDisp, tVgaOut exp, logic expDisp);
      if (got !== exp)
         stopOnError($sformatf("** Error: vgaOut got 0x%04h expected 0x%04h", got, exp));
      else if (gotDisp !== expDisp)
         stopOnError($sformatf("** Error: inDisplayArea got 0x%h expected 0x%h",
                               gotDisp, expDisp));
   endtask

   task automatic checkFpgaOut(tFpgaOut got, tFpgaOut exp);
      if (got.led !== exp.led)
         stopOnError($sformatf("** Error: fpgaLed got 0x%03h expected 0x%03h", got.led, exp.led));
      else if (got.seg7 !== exp.seg7)
         stopOnError($sformatf("** Error: fpgaSeg7 got 0x%012h expected 0x%012h",
                               got.seg7, exp.seg7));
   endtask

   task automatic checkPop(logic got, logic exp);
      if (got !== exp)
         stopOnError($sformatf("** Error: kbdPop got 0x%h expected 0x%h", got, exp));
   endtask

   // ==========================================================================
   // Bus accesses start and end 1 ns after a rising edge
   // ==========================================================================
   task automatic busWrite(logic [31:0] addr, logic [31:0] data, logic [3:0] be);
      coreReq.address = addr;
      coreReq.data    = data;
      coreReq.byteEn  = be;
      coreReq.wrEn    = 1'b1;
      @(posedge Clock);
      #1;
      coreReq.wrEn    = 1'b0;
   endtask

   task automatic busRead(logic [31:0] addr, output logic [31:0] data, output logic popSeen);
      coreReq.address = addr;
      coreReq.rdEn    = 1'b1;
      @(negedge Clock);
      popSeen = kbdPop;          // Pop belongs to the strobe cycle
      @(posedge Clock);
      #1;
      coreReq.rdEn    = 1'b0;
      data            = dMemRdRsp; // Q104H
   endtask

   task automatic driveKeyboard();
      kbdValid    = (kbdQueue.size() > 0);
      kbdScanCode = kbdValid ? kbdQueue[0] : 8'h00;
   endtask

   // ==========================================================================
   // Model
   // ==========================================================================
   task automatic modelCrWrite(tCrReg off, logic [31:0] data, logic [3:0] be);
      case (off)
         CR_LED: begin
            if (be[0]) ledModel[7:0] = data[7:0];
            if (be[1]) ledModel[9:8] = data[9:8];
         end
         CR_SEG7_0: for (int b = 0; b < 4; b++) if (be[b]) segModel[b] = data[8*b +: 8];
         CR_SEG7_1: for (int b = 0; b < 2; b++) if (be[b]) segModel[4+b] = data[8*b +: 8];
         default: ;
      endcase
   endtask

   function automatic logic [31:0] crRegExpected(tCrReg off);
      case (off)
         CR_LED:    return {22'b0, ledModel};
         CR_SEG7_0: return {segModel[3], segModel[2], segModel[1], segModel[0]};
         CR_SEG7_1: return {16'b0, segModel[5], segModel[4]};
         default:   return 32'b0;
      endcase
   endfunction

   function automatic tFpgaOut fpgaOutModel();
      tFpgaOut o;
      o.led = ledModel;
      for (int b = 0; b < 6; b++) o.seg7[b] = segModel[b];
      return o;
   endfunction

   function automatic logic inArea(int x, int y);
      return (x < `H_VISIBLE) && (y < `V_VISIBLE);
   endfunction

   function automatic tVgaOut vgaModel(int x, int y);
      tVgaOut v;
      logic   pixelOn;
      pixelOn = 1'b0;
      if (inArea(x, y)) pixelOn = fbModel[14'(y * `VGA_WORDS_PER_LINE + x / 32)][5'(x % 32)];
      v.red   = pixelOn ? 4'hF : 4'h0;
      v.green = pixelOn ? 4'hF : 4'h0;
      v.blue  = pixelOn ? 4'hF : 4'h0;
      v.hSync = !((x >= `H_VISIBLE + `H_FRONT) && (x < `H_VISIBLE + `H_FRONT + `H_SYNC));
      v.vSync = !((y >= `V_VISIBLE + `V_FRONT) && (y < `V_VISIBLE + `V_FRONT + `V_SYNC));
      return v;
   endfunction

   function automatic bit isMapped(logic [31:0] addr);
      return ((addr >= `CR_MEM_BASE) && (addr < `CR_MEM_BASE + `CR_MEM_SIZE)) ||
             ((addr >= `VGA_MEM_BASE) && (addr < `VGA_MEM_BASE + `VGA_MEM_WORDS * 4));
   endfunction

   // Scan position counts one pixel per clock from reset release
   always @(posedge Clock) begin
      if (rstN) begin
         histX[2] = histX[1];
         histY[2] = histY[1];
         histX[1] = histX[0];
         histY[1] = histY[0];
         if (histX[0] == `H_TOTAL - 1) begin
            histX[0] = 0;
            histY[0] = (histY[0] == `V_TOTAL - 1) ? 0 : histY[0] + 1;
         end else begin
            histX[0] = histX[0] + 1;
         end
      end
   end

   always @(negedge Clock) begin
      if (scanCheckOn)   // Outputs lag the counters by two clocks
         checkVgaOut(vgaOut, inDisplayArea, vgaModel(histX[2], histY[2]),
                     inArea(histX[2], histY[2]));
   end

   // ==========================================================================
   // Test sequence
   // ==========================================================================
   initial begin
      logic [31:0]  addr;
      logic [31:0]  data;
      logic [31:0]  got;
      logic [13:0]  idx;
      logic [3:0]   be;
      logic         pop;
      logic [7:0]   head;
      tCrReg        off;
      tVgaOut       idleVga;
      longint       cyc;
      void'($urandom(67331));
      rstN        = 1'b0;
      coreReq     = '0;
      kbdScanCode = 8'h00;
      kbdValid    = 1'b0;
      fpgaSwitch  = '0;
      fpgaKey     = '0;
      scanCheckOn = 1'b0;
      ledModel    = '0;
      for (int b = 0; b < 6; b++) segModel[b] = 8'h00;
      repeat (5) @(posedge Clock);
      #1;
      idleVga       = '0;
      idleVga.hSync = 1'b1;   // Syncs idle high
      idleVga.vSync = 1'b1;
      checkVgaOut(vgaOut, inDisplayArea, idleVga, 1'b0);
      checkFpgaOut(fpgaOutDut, fpgaOutModel());
      checkPop(kbdPop, 1'b0);
      rstN = 1'b1;

      // LED and seven-segment writes with byte enables
      for (int i = 0; i < 40; i++) begin
         case ($urandom_range(2))
            0:       off = CR_LED;
            1:       off = CR_SEG7_0;
            default: off = CR_SEG7_1;
         endcase
         data = $urandom;
         be   = 4'($urandom);
         busWrite(`CR_MEM_BASE + 32'(off), data, be);
         modelCrWrite(off, data, be);
         busRead(`CR_MEM_BASE + 32'(off), got, pop);
         checkRdRsp(got, crRegExpected(off));
         checkFpgaOut(fpgaOutDut, fpgaOutModel());
      end

      // Switch and key levels
      for (int i = 0; i < 20; i++) begin
         fpgaSwitch = 10'($urandom);
         fpgaKey    = 4'($urandom);
         @(posedge Clock);
         #1;
         busRead(`CR_MEM_BASE + 32'(CR_SWITCH), got, pop);
         checkRdRsp(got, {22'b0, fpgaSwitch});
         busRead(`CR_MEM_BASE + 32'(CR_KEY), got, pop);
         checkRdRsp(got, {28'b0, fpgaKey});
      end

      // Two extra keyboard reads run past the empty queue
      for (int i = 0; i < 12; i++) kbdQueue.push_back(8'($urandom));
      driveKeyboard();
      for (int i = 0; i < 14; i++) begin
         busRead(`CR_MEM_BASE + 32'(CR_KBD_READY), got, pop);
         checkRdRsp(got, {31'b0, (kbdQueue.size() > 0)});
         checkPop(pop, 1'b0);
         head = (kbdQueue.size() > 0) ? kbdQueue[0] : 8'h00;
         busRead(`CR_MEM_BASE + 32'(CR_KBD_SCANCODE), got, pop);
         checkRdRsp(got, {24'b0, head});
         checkPop(pop, (kbdQueue.size() > 0));
         if (kbdQueue.size() > 0) void'(kbdQueue.pop_front());
         driveKeyboard();
      end

      // Frame buffer fill followed by random byte-enabled traffic
      for (int i = 0; i < `VGA_MEM_WORDS; i++) begin
         idx  = 14'(i);
         data = $urandom;
         busWrite(`VGA_MEM_BASE + {16'b0, idx, 2'b00}, data, 4'hF);
         fbModel[idx] = data;
      end
      for (int i = 0; i < 200; i++) begin
         idx  = 14'($urandom_range(`VGA_MEM_WORDS - 1));
         addr = `VGA_MEM_BASE + {16'b0, idx, 2'b00};
         if ($urandom_range(1) == 0) begin
            data = $urandom;
            be   = 4'($urandom);
            busWrite(addr, data, be);
            for (int b = 0; b < 4; b++) if (be[b]) fbModel[idx][8*b +: 8] = data[8*b +: 8];
         end else begin
            busRead(addr, got, pop);
            checkRdRsp(got, fbModel[idx]);
         end
      end

      // Unmapped accesses leave every aliased register and word alone
      for (int i = 0; i < 60; i++) begin
         do begin
            case ($urandom_range(3))
               0:       addr = $urandom;
               1:       addr = `VGA_MEM_BASE + `VGA_MEM_WORDS * 4 + 4 * $urandom_range(255);
               2:       addr = `CR_MEM_BASE - 4 * ($urandom_range(63) + 1);
               default: addr = `CR_MEM_BASE + `CR_MEM_SIZE + 32'(CR_LED) + 4 * $urandom_range(2);
            endcase
            addr = addr & ~32'h3;
         end while (isMapped(addr));
         busWrite(addr, $urandom, 4'hF);
         busRead(addr, got, pop);
         checkRdRsp(got, 32'b0);
         checkPop(pop, 1'b0);
         checkFpgaOut(fpgaOutDut, fpgaOutModel());
         idx = addr[15:2];   // Frame buffer word sharing the low address bits
         if (idx < `VGA_MEM_WORDS) begin
            busRead(`VGA_MEM_BASE + {16'b0, idx, 2'b00}, got, pop);
            checkRdRsp(got, fbModel[idx]);
         end
      end
      for (int i = 0; i < 20; i++) begin
         idx = 14'($urandom_range(`VGA_MEM_WORDS - 1));
         busRead(`VGA_MEM_BASE + {16'b0, idx, 2'b00}, got, pop);
         checkRdRsp(got, fbModel[idx]);
      end

      // Two frames of scan-out from a random phase
      repeat ($urandom_range(32'(FRAME_CYCLES) - 1)) @(posedge Clock);
      #1;
      scanCheckOn = 1'b1;
      cyc         = 0;
      while (cyc < 2 * FRAME_CYCLES) begin
         if ($urandom_range(63) == 0) begin
            if ($urandom_range(1) == 0) begin
               data = 32'(histX[0]);   // Counter at the strobe cycle
               busRead(`CR_MEM_BASE + 32'(CR_VGA_X), got, pop);
            end else begin
               data = 32'(histY[0]);
               busRead(`CR_MEM_BASE + 32'(CR_VGA_Y), got, pop);
            end
            checkRdRsp(got, data);
         end else begin
            @(posedge Clock);
            #1;
         end
         cyc++;
      end
      scanCheckOn = 1'b0;

      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: dMemSs.f
+incdir+logic
logic/dMemSsPkg.sv
logic/dMemReqIf.sv
logic/dMemRouter.sv
logic/crMem.sv
logic/vgaCtrl.sv
logic/dMemSs.sv
tests/dMemSsTb.sv

// File: Makefile
TOP = dMemSsTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f dMemSs.f --top-module $(TOP)

obj_dir/V$(TOP): dMemSs.f logic/*.sv logic/*.svh tests/*.sv
	verilator --binary --timing --timescale 1ns/100ps -f dMemSs.f \
		--top-module $(TOP) -Mdir obj_dir

# Pass only when the run prints the pass line
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
